//--- design/core_pkg.sv
package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_ctl_w  = 5;

    // major opcodes.
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // function field of r-type words.
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_xor = 6'h26;
    localparam logic [5:0] fn_slt = 6'h2a;

    // alu operation select.
    localparam logic [alu_ctl_w-1:0] alu_add = 5'd0;
    localparam logic [alu_ctl_w-1:0] alu_sub = 5'd1;
    localparam logic [alu_ctl_w-1:0] alu_and = 5'd2;
    localparam logic [alu_ctl_w-1:0] alu_or  = 5'd3;
    localparam logic [alu_ctl_w-1:0] alu_xor = 5'd4;
    localparam logic [alu_ctl_w-1:0] alu_slt = 5'd5;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_type_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [15:0]           imm;
    } i_type_t;

    // one instruction word, seen as either format.
    typedef union packed {
        r_type_t r_fields;
        i_type_t i_fields;
    } instr_t;

endpackage

//--- design/alu.sv
module alu (
    input  logic [core_pkg::alu_ctl_w-1:0] ctl,
    input  logic [core_pkg::xlen-1:0]      a,
    input  logic [core_pkg::xlen-1:0]      b,
    output logic [core_pkg::xlen-1:0]      y,
    output logic                           zero
);

    import core_pkg::*;

    logic less;

    // signed compare for slt.
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (ctl)
            alu_add: begin
                y = a + b;
            end
            alu_sub: begin
                y = a - b;
            end
            alu_and: begin
                y = a & b;
            end
            alu_or: begin
                y = a | b;
            end
            alu_xor: begin
                y = a ^ b;
            end
            alu_slt: begin
                y = {{(xlen-1){1'b0}}, less};
            end
            default: begin
                y = '0;
            end
        endcase
    end

    // kept for branch compare.
    assign zero = (y == '0);

endmodule

//--- design/regfile.sv
module regfile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [core_pkg::reg_addr_w-1:0] raddr1,
    input  logic [core_pkg::reg_addr_w-1:0] raddr2,
    output logic [core_pkg::xlen-1:0]       rdata1,
    output logic [core_pkg::xlen-1:0]       rdata2,
    input  logic                            we,
    input  logic [core_pkg::reg_addr_w-1:0] waddr,
    input  logic [core_pkg::xlen-1:0]       wdata
);

    import core_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];
    logic            wr_ok;

    // r0 is never written, so it stays zero after reset.
    assign wr_ok = we && (waddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle writeback is passed straight to the readers.
    assign rdata1 = (wr_ok && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (wr_ok && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

//--- design/decode.sv
module decode (
    input  logic                            clk,
    input  logic                            rst,
    input  core_pkg::instr_t                instr,
    output logic [core_pkg::xlen-1:0]       pc,
    output logic [core_pkg::xlen-1:0]       imm,
    output logic [core_pkg::alu_ctl_w-1:0]  ctl,
    output logic                            src_imm,
    output logic [core_pkg::reg_addr_w-1:0] reg1_addr,
    output logic [core_pkg::reg_addr_w-1:0] reg2_addr,
    output logic [core_pkg::xlen-1:0]       reg1_data,
    output logic [core_pkg::xlen-1:0]       reg2_data,
    output logic [core_pkg::reg_addr_w-1:0] write_reg_in,
    output logic                            reg_write_in,
    output logic                            mem_write_in,
    output logic                            mem_read_in,
    output logic [core_pkg::reg_addr_w-1:0] rf_raddr1,
    output logic [core_pkg::reg_addr_w-1:0] rf_raddr2,
    input  logic [core_pkg::xlen-1:0]       rf_rdata1,
    input  logic [core_pkg::xlen-1:0]       rf_rdata2,
    input  logic                            exmem_mem_read,
    input  logic [core_pkg::reg_addr_w-1:0] exmem_write_reg,
    output logic                            stall
);

    import core_pkg::*;

    instr_t                if_id;
    logic [alu_ctl_w-1:0]  dec_ctl;
    logic                  dec_src_imm;
    logic                  dec_zext;
    logic                  dec_reg_write;
    logic                  dec_mem_write;
    logic                  dec_mem_read;
    logic                  dec_uses_rs;
    logic                  dec_uses_rt;
    logic [reg_addr_w-1:0] dec_write_reg;
    logic [xlen-1:0]       dec_imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= '0;
            if_id <= '0;
        end else if (!stall) begin
            pc    <= pc + 4;
            if_id <= instr;
        end
    end

    always_comb begin
        dec_ctl       = alu_add;
        dec_src_imm   = 1'b0;
        dec_zext      = 1'b0;
        dec_reg_write = 1'b0;
        dec_mem_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_uses_rs   = 1'b1;
        dec_uses_rt   = 1'b0;
        dec_write_reg = if_id.i_fields.rt;
        case (if_id.r_fields.opcode)
            op_rtype: begin
                dec_uses_rt   = 1'b1;
                dec_reg_write = 1'b1;
                dec_write_reg = if_id.r_fields.rd;
                case (if_id.r_fields.funct)
                    fn_add:  dec_ctl = alu_add;
                    fn_sub:  dec_ctl = alu_sub;
                    fn_and:  dec_ctl = alu_and;
                    fn_or:   dec_ctl = alu_or;
                    fn_xor:  dec_ctl = alu_xor;
                    fn_slt:  dec_ctl = alu_slt;
                    default: dec_reg_write = 1'b0;
                endcase
            end
            op_addi: begin
                dec_src_imm   = 1'b1;
                dec_reg_write = 1'b1;
            end
            op_andi, op_ori: begin
                dec_ctl       = (if_id.i_fields.opcode == op_andi) ? alu_and : alu_or;
                dec_src_imm   = 1'b1;
                dec_zext      = 1'b1;
                dec_reg_write = 1'b1;
            end
            op_lw: begin
                dec_src_imm   = 1'b1;
                dec_reg_write = 1'b1;
                dec_mem_read  = 1'b1;
            end
            op_sw: begin
                dec_src_imm   = 1'b1;
                dec_mem_write = 1'b1;
                dec_uses_rt   = 1'b1;
            end
            default: begin
                dec_uses_rs = 1'b0;
            end
        endcase
    end

    assign dec_imm = dec_zext ? {{(xlen-16){1'b0}}, if_id.i_fields.imm}
                              : {{(xlen-16){if_id.i_fields.imm[15]}}, if_id.i_fields.imm};

    // load-use: the load sits in ex/mem, its consumer in id/ex.
    assign stall = exmem_mem_read &&
                   (((reg1_addr != '0) && (reg1_addr == exmem_write_reg)) ||
                    ((reg2_addr != '0) && (reg2_addr == exmem_write_reg)));

    // while stalled the held operands are re-read, so a writeback landing now is kept.
    assign rf_raddr1 = stall ? reg1_addr : (dec_uses_rs ? if_id.i_fields.rs : '0);
    assign rf_raddr2 = stall ? reg2_addr : (dec_uses_rt ? if_id.i_fields.rt : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            imm          <= '0;
            ctl          <= '0;
            src_imm      <= 1'b0;
            reg1_addr    <= '0;
            reg2_addr    <= '0;
            reg1_data    <= '0;
            reg2_data    <= '0;
            write_reg_in <= '0;
            reg_write_in <= 1'b0;
            mem_write_in <= 1'b0;
            mem_read_in  <= 1'b0;
        end else if (stall) begin
            reg1_data <= rf_rdata1;
            reg2_data <= rf_rdata2;
        end else begin
            imm          <= dec_imm;
            ctl          <= dec_ctl;
            src_imm      <= dec_src_imm;
            reg1_addr    <= rf_raddr1;
            reg2_addr    <= rf_raddr2;
            reg1_data    <= rf_rdata1;
            reg2_data    <= rf_rdata2;
            write_reg_in <= dec_write_reg;
            reg_write_in <= dec_reg_write;
            mem_write_in <= dec_mem_write;
            mem_read_in  <= dec_mem_read;
        end
    end

endmodule

//--- design/exec.sv
module exec (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [core_pkg::xlen-1:0]       imm,
    input  logic [core_pkg::alu_ctl_w-1:0]  ctl,
    input  logic                            src_imm,
    input  logic [core_pkg::reg_addr_w-1:0] reg1_addr,
    input  logic [core_pkg::reg_addr_w-1:0] reg2_addr,
    input  logic [core_pkg::xlen-1:0]       reg1_data,
    input  logic [core_pkg::xlen-1:0]       reg2_data,
    input  logic [core_pkg::reg_addr_w-1:0] write_reg_in,
    output logic [core_pkg::reg_addr_w-1:0] write_reg_out,
    output logic [core_pkg::xlen-1:0]       result,
    input  logic                            reg_write_in,
    output logic                            reg_write_out,
    input  logic                            mem_write_in,
    output logic                            mem_write_out,
    input  logic                            mem_read_in,
    output logic                            mem_read_out,
    output logic [core_pkg::xlen-1:0]       mem_write_data,
    input  logic                            reg_write_mem,
    input  logic [core_pkg::reg_addr_w-1:0] write_reg_mem,
    input  logic                            stall,
    input  logic [core_pkg::xlen-1:0]       result_mem
);

    import core_pkg::*;

    logic [xlen-1:0] reg1_current;
    logic [xlen-1:0] reg2_current;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_out;

    // r0 first, then the younger ex/mem value, then mem/wb.
    assign reg1_current =
        (reg1_addr == '0) ? '0 :
        (reg_write_out && reg1_addr == write_reg_out) ? result :
        (reg_write_mem && reg1_addr == write_reg_mem) ? result_mem :
        reg1_data;

    assign reg2_current =
        (reg2_addr == '0) ? '0 :
        (reg_write_out && reg2_addr == write_reg_out) ? result :
        (reg_write_mem && reg2_addr == write_reg_mem) ? result_mem :
        reg2_data;

    assign src2 = src_imm ? imm : reg2_current;

    alu alu_i (
        .ctl  (ctl),
        .a    (reg1_current),
        .b    (src2),
        .y    (alu_out),
        .zero ()
    );

    always_ff @(posedge clk) begin
        if (rst || stall) begin
            // a stall leaves a bubble behind the load.
            write_reg_out  <= '0;
            result         <= '0;
            reg_write_out  <= 1'b0;
            mem_write_out  <= 1'b0;
            mem_read_out   <= 1'b0;
            mem_write_data <= '0;
        end else begin
            write_reg_out  <= write_reg_in;
            result         <= alu_out;
            reg_write_out  <= reg_write_in;
            mem_write_out  <= mem_write_in;
            mem_read_out   <= mem_read_in;
            mem_write_data <= reg2_current;
        end
    end

endmodule

//--- design/mem_stage.sv
module mem_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [core_pkg::xlen-1:0]       result,
    input  logic [core_pkg::reg_addr_w-1:0] write_reg,
    input  logic                            reg_write,
    input  logic                            mem_read,
    input  logic                            mem_write,
    input  logic [core_pkg::xlen-1:0]       mem_write_data,
    output logic [core_pkg::xlen-1:0]       dmem_addr,
    output logic [core_pkg::xlen-1:0]       dmem_wdata,
    output logic                            dmem_we,
    output logic                            dmem_re,
    input  logic [core_pkg::xlen-1:0]       dmem_rdata,
    output logic [core_pkg::reg_addr_w-1:0] wb_reg,
    output logic [core_pkg::xlen-1:0]       wb_data,
    output logic                            wb_en
);

    // the data bus comes straight from ex/mem.
    assign dmem_addr  = result;
    assign dmem_wdata = mem_write_data;
    assign dmem_we    = mem_write;
    assign dmem_re    = mem_read;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_reg  <= '0;
            wb_data <= '0;
            wb_en   <= 1'b0;
        end else begin
            wb_reg  <= write_reg;
            wb_en   <= reg_write;
            // loads take the bus data, everything else the alu result.
            wb_data <= mem_read ? dmem_rdata : result;
        end
    end

endmodule

//--- design/core_top.sv
module core_top (
    input  logic                      clk,
    input  logic                      rst,
    output logic [core_pkg::xlen-1:0] pc,
    input  core_pkg::instr_t          instr,
    output logic [core_pkg::xlen-1:0] dmem_addr,
    output logic [core_pkg::xlen-1:0] dmem_wdata,
    output logic                      dmem_we,
    output logic                      dmem_re,
    input  logic [core_pkg::xlen-1:0] dmem_rdata
);

    import core_pkg::*;

    // id/ex.
    logic [xlen-1:0]       imm;
    logic [alu_ctl_w-1:0]  ctl;
    logic                  src_imm;
    logic [reg_addr_w-1:0] reg1_addr;
    logic [reg_addr_w-1:0] reg2_addr;
    logic [xlen-1:0]       reg1_data;
    logic [xlen-1:0]       reg2_data;
    logic [reg_addr_w-1:0] write_reg_in;
    logic                  reg_write_in;
    logic                  mem_write_in;
    logic                  mem_read_in;
    logic                  stall;

    // register file read side.
    logic [reg_addr_w-1:0] rf_raddr1;
    logic [reg_addr_w-1:0] rf_raddr2;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;

    // ex/mem.
    logic [reg_addr_w-1:0] write_reg_out;
    logic [xlen-1:0]       result;
    logic                  reg_write_out;
    logic                  mem_write_out;
    logic                  mem_read_out;
    logic [xlen-1:0]       mem_write_data;

    // mem/wb.
    logic [reg_addr_w-1:0] wb_reg;
    logic [xlen-1:0]       wb_data;
    logic                  wb_en;

    decode decode_i (
        .clk             (clk),
        .rst             (rst),
        .instr           (instr),
        .pc              (pc),
        .imm             (imm),
        .ctl             (ctl),
        .src_imm         (src_imm),
        .reg1_addr       (reg1_addr),
        .reg2_addr       (reg2_addr),
        .reg1_data       (reg1_data),
        .reg2_data       (reg2_data),
        .write_reg_in    (write_reg_in),
        .reg_write_in    (reg_write_in),
        .mem_write_in    (mem_write_in),
        .mem_read_in     (mem_read_in),
        .rf_raddr1       (rf_raddr1),
        .rf_raddr2       (rf_raddr2),
        .rf_rdata1       (rf_rdata1),
        .rf_rdata2       (rf_rdata2),
        .exmem_mem_read  (mem_read_out),
        .exmem_write_reg (write_reg_out),
        .stall           (stall)
    );

    regfile regfile_i (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_en),
        .waddr  (wb_reg),
        .wdata  (wb_data)
    );

    exec exec_i (
        .clk            (clk),
        .rst            (rst),
        .imm            (imm),
        .ctl            (ctl),
        .src_imm        (src_imm),
        .reg1_addr      (reg1_addr),
        .reg2_addr      (reg2_addr),
        .reg1_data      (reg1_data),
        .reg2_data      (reg2_data),
        .write_reg_in   (write_reg_in),
        .write_reg_out  (write_reg_out),
        .result         (result),
        .reg_write_in   (reg_write_in),
        .reg_write_out  (reg_write_out),
        .mem_write_in   (mem_write_in),
        .mem_write_out  (mem_write_out),
        .mem_read_in    (mem_read_in),
        .mem_read_out   (mem_read_out),
        .mem_write_data (mem_write_data),
        .reg_write_mem  (wb_en),
        .write_reg_mem  (wb_reg),
        .stall          (stall),
        .result_mem     (wb_data)
    );

    mem_stage mem_stage_i (
        .clk            (clk),
        .rst            (rst),
        .result         (result),
        .write_reg      (write_reg_out),
        .reg_write      (reg_write_out),
        .mem_read       (mem_read_out),
        .mem_write      (mem_write_out),
        .mem_write_data (mem_write_data),
        .dmem_addr      (dmem_addr),
        .dmem_wdata     (dmem_wdata),
        .dmem_we        (dmem_we),
        .dmem_re        (dmem_re),
        .dmem_rdata     (dmem_rdata),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data),
        .wb_en          (wb_en)
    );

endmodule

//--- bench/core_tb.sv
module core_tb;

    import core_pkg::*;

    localparam int imem_depth    = 64;
    localparam int dmem_depth    = 256;
    localparam int reset_cycles  = 16;
    localparam int program_runs  = 8;
    // each run is reset plus at most two cycles per instruction slot.
    localparam int timeout_limit = program_runs * (reset_cycles + 2 + 2 * imem_depth) + 200;
    localparam logic [31:0] seed = 32'd82433;

    logic            clk;
    logic            rst;
    logic [xlen-1:0] pc;
    instr_t          instr;
    logic [xlen-1:0] dmem_addr;
    logic [xlen-1:0] dmem_wdata;
    logic            dmem_we;
    logic            dmem_re;
    logic [xlen-1:0] dmem_rdata;

    instr_t      imem [imem_depth];
    logic [31:0] dmem [dmem_depth];
    logic [31:0] dmem_init [dmem_depth];
    int          prog_len;
    int          cycle_count = 0;
    int          start_cycle;
    int          log_base;
    int          mismatch_count;
    int          other_count;
    logic [31:0] lcg_state;

    logic [31:0] store_addr_q [$];
    logic [31:0] store_data_q [$];
    int          store_cycle_q [$];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    int          exp_cycle_q [$];

    core_top uut (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .instr      (instr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    assign instr      = imem[pc[7:2]];
    // read data is only returned while the core asks for it.
    assign dmem_rdata = (rst || !dmem_re) ? '0 : dmem[dmem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // the data memory takes its image while the core is held in reset.
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= dmem_init[i];
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    always @(negedge clk) begin
        if (!rst && dmem_we) begin
            store_addr_q.push_back(dmem_addr);
            store_data_q.push_back(dmem_wdata);
            store_cycle_q.push_back(cycle_count - start_cycle);
        end
    end

    initial begin
        wait (cycle_count >= timeout_limit);
        $display("timeout: the tests did not finish within %0d cycles", timeout_limit);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count + 1);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic instr_t rtype_word(logic [5:0] fn, logic [4:0] rd, logic [4:0] rs,
                                          logic [4:0] rt);
        instr_t w;
        w.r_fields.opcode = op_rtype;
        w.r_fields.rs     = rs;
        w.r_fields.rt     = rt;
        w.r_fields.rd     = rd;
        w.r_fields.shamt  = '0;
        w.r_fields.funct  = fn;
        return w;
    endfunction

    function automatic instr_t itype_word(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
                                          logic [15:0] imm);
        instr_t w;
        w.i_fields.opcode = op;
        w.i_fields.rs     = rs;
        w.i_fields.rt     = rt;
        w.i_fields.imm    = imm;
        return w;
    endfunction

    function automatic void emit(instr_t w);
        imem[prog_len] = w;
        prog_len++;
    endfunction

    task automatic compare_value(string name, string what, logic [31:0] expected,
                                 logic [31:0] actual);
        assert (actual === expected) else begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %h, actual %h", name, what, expected, actual);
        end
    endtask

    // sequential model of the instruction rules, with one extra cycle per load-use pair.
    task automatic build_expected();
        logic [31:0] r [32];
        logic [31:0] mem [dmem_depth];
        instr_t      w;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  load_dest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] ea;
        logic        known;
        logic        uses_rt;
        int          stalls;
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_cycle_q.delete();
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        for (int i = 0; i < dmem_depth; i++) begin
            mem[i] = dmem_init[i];
        end
        stalls    = 0;
        load_dest = '0;
        for (int i = 0; i < prog_len; i++) begin
            w       = imem[i];
            rs      = w.i_fields.rs;
            rt      = w.i_fields.rt;
            a       = r[rs];
            b       = r[rt];
            simm    = {{16{w.i_fields.imm[15]}}, w.i_fields.imm};
            zimm    = {16'h0000, w.i_fields.imm};
            ea      = a + simm;
            known   = w.r_fields.opcode inside {op_rtype, op_addi, op_andi, op_ori, op_lw, op_sw};
            uses_rt = w.r_fields.opcode inside {op_rtype, op_sw};
            if (load_dest != '0 && known && (rs == load_dest || (uses_rt && rt == load_dest))) begin
                stalls++;
            end
            load_dest = '0;
            case (w.r_fields.opcode)
                op_rtype: begin
                    case (w.r_fields.funct)
                        fn_add:  r[w.r_fields.rd] = a + b;
                        fn_sub:  r[w.r_fields.rd] = a - b;
                        fn_and:  r[w.r_fields.rd] = a & b;
                        fn_or:   r[w.r_fields.rd] = a | b;
                        fn_xor:  r[w.r_fields.rd] = a ^ b;
                        fn_slt:  r[w.r_fields.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                op_addi: r[rt] = ea;
                op_andi: r[rt] = a & zimm;
                op_ori:  r[rt] = a | zimm;
                op_lw: begin
                    r[rt]     = mem[ea[9:2]];
                    load_dest = rt;
                end
                op_sw: begin
                    mem[ea[9:2]] = b;
                    exp_addr_q.push_back(ea);
                    exp_data_q.push_back(b);
                    exp_cycle_q.push_back(i + 3 + stalls);
                end
                default: ;
            endcase
            r[0] = '0;
        end
    endtask

    task automatic check_stores(string name);
        int j;
        for (int k = 0; k < exp_addr_q.size(); k++) begin
            j = log_base + k;
            assert (j < store_addr_q.size()) else begin
                other_count++;
                $display("%s: store of %h to address %h never reached the data bus",
                         name, exp_data_q[k], exp_addr_q[k]);
            end
            if (j < store_addr_q.size()) begin
                compare_value(name, $sformatf("store %0d address", k), exp_addr_q[k],
                              store_addr_q[j]);
                compare_value(name, $sformatf("store %0d data", k), exp_data_q[k],
                              store_data_q[j]);
                compare_value(name, $sformatf("store %0d cycle", k), 32'(exp_cycle_q[k]),
                              32'(store_cycle_q[j]));
            end
        end
        assert (store_addr_q.size() <= log_base + exp_addr_q.size()) else begin
            other_count++;
            $display("%s: the core made more stores than the program holds", name);
        end
    endtask

    // holds the core in reset and gives both memories a fresh image.
    task automatic begin_program();
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < imem_depth; i++) begin
            imem[i] = rtype_word(fn_add, 5'd0, 5'd0, 5'd0);
        end
        for (int i = 0; i < dmem_depth; i++) begin
            dmem_init[i] = 32'(i + 1) * 32'h9e37_79b9;
        end
        prog_len = 0;
    endtask

    task automatic run_program(string name, int quiet_cycles);
        int          cyc;
        logic [31:0] end_pc;
        repeat (4) emit(rtype_word(fn_add, 5'd0, 5'd0, 5'd0));
        end_pc = 32'(prog_len * 4);
        build_expected();
        repeat (reset_cycles) @(posedge clk);
        #1;
        assert (pc === '0) else begin
            other_count++;
            $display("%s: pc is %h at the end of reset instead of zero", name, pc);
        end
        rst         = 1'b0;
        start_cycle = cycle_count;
        log_base    = store_addr_q.size();
        do begin
            @(negedge clk);
            cyc = cycle_count - start_cycle;
            if (cyc < quiet_cycles) begin
                assert (!dmem_we && !dmem_re) else begin
                    other_count++;
                    $display("%s: data bus active in cycle %0d before any memory instruction",
                             name, cyc);
                end
            end
        end while (pc != end_pc);
        check_stores(name);
    endtask

    task automatic alu_ops_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        for (int n = 0; n < 3; n++) begin
            begin_program();
            a = lcg_next();
            b = lcg_next();
            r = lcg_next();
            if (n == 0) begin
                // opposite signs, so slt differs from an unsigned compare.
                a[31] = 1'b1;
                b[31] = 1'b0;
            end
            dmem_init[1] = a;
            dmem_init[2] = b;
            emit(itype_word(op_lw, 5'd1, 5'd0, 16'd4));
            emit(itype_word(op_lw, 5'd2, 5'd0, 16'd8));
            emit(rtype_word(fn_add, 5'd3, 5'd1, 5'd2));
            emit(rtype_word(fn_sub, 5'd4, 5'd1, 5'd2));
            emit(rtype_word(fn_and, 5'd5, 5'd1, 5'd2));
            emit(rtype_word(fn_or, 5'd6, 5'd1, 5'd2));
            emit(rtype_word(fn_xor, 5'd7, 5'd1, 5'd2));
            emit(rtype_word(fn_slt, 5'd8, 5'd1, 5'd2));
            emit(rtype_word(fn_slt, 5'd9, 5'd2, 5'd1));
            emit(itype_word(op_addi, 5'd10, 5'd1, r[15:0]));
            emit(itype_word(op_andi, 5'd11, 5'd1, r[31:16] | 16'h8000));
            emit(itype_word(op_ori, 5'd12, 5'd2, r[31:16] | 16'h8000));
            for (int k = 3; k <= 12; k++) begin
                emit(itype_word(op_sw, 5'(k), 5'd0, 16'(64 + 4 * k)));
            end
            run_program($sformatf("alu_ops round %0d", n), 0);
        end
    endtask

    task automatic forwarding_test();
        begin_program();
        dmem_init[1] = lcg_next();
        emit(itype_word(op_lw, 5'd1, 5'd0, 16'd4));
        emit(itype_word(op_addi, 5'd2, 5'd1, 16'd5));
        emit(rtype_word(fn_add, 5'd3, 5'd2, 5'd1));
        emit(rtype_word(fn_xor, 5'd4, 5'd3, 5'd2));
        emit(rtype_word(fn_add, 5'd0, 5'd0, 5'd0));
        emit(rtype_word(fn_or, 5'd5, 5'd4, 5'd3));
        emit(rtype_word(fn_add, 5'd0, 5'd0, 5'd0));
        emit(rtype_word(fn_add, 5'd0, 5'd0, 5'd0));
        emit(rtype_word(fn_sub, 5'd6, 5'd1, 5'd5));
        emit(rtype_word(fn_add, 5'd7, 5'd6, 5'd6));
        emit(rtype_word(fn_slt, 5'd8, 5'd7, 5'd6));
        for (int k = 2; k <= 8; k++) begin
            emit(itype_word(op_sw, 5'(k), 5'd0, 16'(96 + 4 * k)));
        end
        run_program("forwarding", 0);
    endtask

    task automatic load_use_test();
        begin_program();
        dmem_init[2] = lcg_next();
        dmem_init[3] = lcg_next();
        dmem_init[5] = 32'd160;
        emit(itype_word(op_lw, 5'd1, 5'd0, 16'd8));
        emit(rtype_word(fn_add, 5'd2, 5'd1, 5'd1));
        emit(itype_word(op_sw, 5'd2, 5'd0, 16'd128));
        emit(itype_word(op_lw, 5'd3, 5'd0, 16'd12));
        emit(itype_word(op_sw, 5'd3, 5'd0, 16'd132));
        emit(itype_word(op_addi, 5'd4, 5'd0, 16'd16));
        emit(itype_word(op_lw, 5'd5, 5'd4, 16'd0));
        emit(rtype_word(fn_sub, 5'd6, 5'd5, 5'd3));
        emit(itype_word(op_sw, 5'd6, 5'd0, 16'd136));
        emit(itype_word(op_lw, 5'd7, 5'd0, 16'd20));
        emit(itype_word(op_sw, 5'd3, 5'd7, 16'd0));
        run_program("load_use", 0);
    endtask

    task automatic zero_reg_test();
        begin_program();
        emit(itype_word(op_addi, 5'd0, 5'd0, 16'd55));
        emit(rtype_word(fn_add, 5'd1, 5'd0, 5'd0));
        emit(itype_word(op_addi, 5'd2, 5'd0, 16'd7));
        emit(itype_word(op_lw, 5'd0, 5'd0, 16'd4));
        emit(rtype_word(fn_add, 5'd3, 5'd0, 5'd2));
        emit(rtype_word(fn_or, 5'd4, 5'd0, 5'd0));
        emit(itype_word(op_sw, 5'd1, 5'd0, 16'd192));
        emit(itype_word(op_sw, 5'd3, 5'd0, 16'd196));
        emit(rtype_word(fn_add, 5'd0, 5'd2, 5'd2));
        emit(itype_word(op_sw, 5'd0, 5'd0, 16'd200));
        emit(itype_word(op_sw, 5'd4, 5'd0, 16'd204));
        run_program("zero_reg", 0);
    endtask

    task automatic store_forward_test();
        begin_program();
        emit(itype_word(op_addi, 5'd1, 5'd0, 16'h0123));
        emit(itype_word(op_sw, 5'd1, 5'd0, 16'd64));
        emit(itype_word(op_addi, 5'd2, 5'd0, 16'h0456));
        emit(rtype_word(fn_add, 5'd0, 5'd0, 5'd0));
        emit(itype_word(op_sw, 5'd2, 5'd0, 16'd68));
        emit(itype_word(op_addi, 5'd3, 5'd0, 16'd256));
        emit(itype_word(op_sw, 5'd1, 5'd3, 16'd8));
        emit(rtype_word(fn_xor, 5'd4, 5'd1, 5'd2));
        emit(itype_word(op_sw, 5'd4, 5'd3, 16'd0));
        emit(itype_word(op_addi, 5'd5, 5'd4, 16'hffff));
        emit(rtype_word(fn_add, 5'd0, 5'd0, 5'd0));
        emit(rtype_word(fn_add, 5'd0, 5'd0, 5'd0));
        emit(itype_word(op_sw, 5'd5, 5'd3, 16'd12));
        run_program("store_forward", 0);
    endtask

    task automatic reset_test();
        begin_program();
        emit(itype_word(op_addi, 5'd1, 5'd0, 16'd1));
        emit(itype_word(op_addi, 5'd2, 5'd1, 16'd2));
        emit(rtype_word(fn_add, 5'd3, 5'd1, 5'd2));
        // r7 and r5 hold values from earlier runs until reset clears them.
        emit(rtype_word(fn_or, 5'd4, 5'd3, 5'd7));
        emit(itype_word(op_sw, 5'd4, 5'd0, 16'd64));
        emit(itype_word(op_sw, 5'd5, 5'd0, 16'd68));
        // first memory instruction sits at index 4.
        run_program("reset", 4 + 3);
    endtask

    initial begin
        rst            = 1'b1;
        lcg_state      = seed;
        mismatch_count = 0;
        other_count    = 0;
        prog_len       = 0;
        start_cycle    = 0;
        log_base       = 0;
        for (int i = 0; i < imem_depth; i++) begin
            imem[i] = rtype_word(fn_add, 5'd0, 5'd0, 5'd0);
        end
        for (int i = 0; i < dmem_depth; i++) begin
            dmem_init[i] = '0;
        end
        alu_ops_test();
        forwarding_test();
        load_use_test();
        zero_reg_test();
        store_forward_test();
        reset_test();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
design/core_pkg.sv
design/alu.sv
design/regfile.sv
design/decode.sv
design/exec.sv
design/mem_stage.sv
design/core_top.sv
bench/core_tb.sv

//--- Makefile
# Verilator build and run of the core testbench.

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module core_tb -Mdir obj_dir -f flist.f
	@out=$$(./obj_dir/Vcore_tb); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
